//--- common/fsab_consts.svh
`ifndef FSAB_CONSTS_SVH
`define FSAB_CONSTS_SVH

// Bus flow control
`define FSAB_CREDITS 4 // Credits held after reset
`define FSAB_LEN_W 4 // Burst length field, up to 15 beats

// Instruction cache geometry
`define IC_LINES 32 // Direct-mapped lines
`define IC_LINE_WORDS 8 // Words per line, one burst per fill
`define IC_INDEX_W 5 // log2 of IC_LINES
`define IC_OFFSET_W 3 // log2 of IC_LINE_WORDS

// Address split for a fetch, byte bits sit below the offset
// [31 : INDEX+OFFSET+2] tag
// [INDEX+OFFSET+1 : OFFSET+2] index
// [OFFSET+1 : 2] word offset
// The index and offset widths must track the counts above

`endif

//--- common/fsab_pkg.sv
`include "fsab_consts.svh"

// Types of the shared system bus
package fsab_pkg;

	// Request direction
	typedef enum logic
	{
		FSAB_READ = 1'b0,
		FSAB_WRITE = 1'b1 // Single beat, no response
	} fsab_mode_t;

	// Device IDs that route the response beats
	typedef enum logic
	{
		FSAB_DID_DPORT = 1'b0, // Uncached data port
		FSAB_DID_ICACHE = 1'b1 // Instruction cache line fill
	} fsab_did_t;

	// Beat count of a request
	typedef logic [`FSAB_LEN_W-1:0] fsab_len_t;

	// Inbound beat broadcast to every client
	typedef struct packed
	{
		logic valid; // Beat present this cycle
		fsab_did_t did; // Owner of the beat
		logic [31:0] data; // Read data
	} fsab_resp_t;

endpackage

//--- common/cpu_port_pkg.sv
// Types seen by the CPU on its fetch and load/store ports
package cpu_port_pkg;

	// Byte address
	typedef logic [31:0] addr_t;

	// Data word
	typedef logic [31:0] word_t;

	// Byte enables with bit n covering bits 8n+7:8n
	typedef logic [3:0] mask_t;

endpackage

//--- common/fsab_req_if.sv
`timescale 1ns/1ps

// One client's request path into the bus arbiter
interface fsab_req_if import fsab_pkg::*, cpu_port_pkg::*; ();
	logic valid; // Request pending
	logic accept; // Taken by the arbiter this cycle
	fsab_mode_t mode; // Read or write
	fsab_did_t did; // Client ID, returned on read beats
	addr_t addr; // Word-aligned start address
	fsab_len_t len; // Beat count
	word_t data; // Write data
	mask_t mask; // Write byte enables

	// Fields stay steady until accept is seen high at an edge
	modport client
	(
		output valid, mode, did, addr, len, data, mask,
		input accept
	);

	modport arbiter
	(
		input valid, mode, did, addr, len, data, mask,
		output accept
	);
endinterface

//--- icache/icache.sv
`timescale 1ns/1ps
`include "fsab_consts.svh"

// Direct-mapped read-only instruction cache, one burst read per miss
module icache import fsab_pkg::*, cpu_port_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic ic_req,
	input addr_t ic_addr,
	output logic ic_wait,
	output word_t ic_data,
	fsab_req_if.client req,
	input fsab_resp_t resp
);
	localparam int TAG_W = 32 - `IC_INDEX_W - `IC_OFFSET_W - 2;

	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [`IC_INDEX_W-1:0] index_t;
	typedef logic [`IC_OFFSET_W-1:0] offset_t;

	typedef enum logic [1:0]
	{
		S_IDLE, // Serving hits
		S_REQ, // Line read waiting for accept
		S_FILL // Taking beats
	} state_t;

	state_t state;
	tag_t tag_mem [`IC_LINES]; // One tag per line
	logic [`IC_LINES-1:0] line_valid;
	word_t data_mem [`IC_LINES*`IC_LINE_WORDS]; // Indexed by {index, offset}

	tag_t cpu_tag;
	index_t cpu_index;
	offset_t cpu_off;
	logic hit;

	tag_t fill_tag; // Line being filled
	index_t fill_index;
	offset_t fill_off; // Next beat's word slot
	logic fill_beat;
	logic fill_last;

	assign cpu_off = ic_addr[`IC_OFFSET_W+1:2];
	assign cpu_index = ic_addr[`IC_INDEX_W+`IC_OFFSET_W+1:`IC_OFFSET_W+2];
	assign cpu_tag = ic_addr[31:`IC_INDEX_W+`IC_OFFSET_W+2];
	assign hit = line_valid[cpu_index] && (tag_mem[cpu_index] == cpu_tag);

	// Held high through the whole fill, drops once the line is valid
	assign ic_wait = ic_req && ((state != S_IDLE) || !hit);

	assign fill_beat = (state == S_FILL) && resp.valid && (resp.did == FSAB_DID_ICACHE);
	assign fill_last = fill_beat && (fill_off == `IC_OFFSET_W'(`IC_LINE_WORDS - 1));

	// Line read at the aligned address
	assign req.valid = (state == S_REQ);
	assign req.mode = FSAB_READ;
	assign req.did = FSAB_DID_ICACHE;
	assign req.addr = {fill_tag, fill_index, `IC_OFFSET_W'(0), 2'b00};
	assign req.len = fsab_len_t'(`IC_LINE_WORDS);
	assign req.data = '0; // No write data on a read
	assign req.mask = '1;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= S_IDLE;
			line_valid <= '0; // Whole cache invalid
			fill_off <= '0;
		end
		else
		begin
			case (state)
				S_IDLE:
					if (ic_req && !hit)
					begin
						state <= S_REQ;
						line_valid[cpu_index] <= 1'b0; // Line is about to be overwritten
						fill_off <= '0;
					end
				S_REQ:
					if (req.accept)
						state <= S_FILL;
				default:
					if (fill_last)
					begin
						state <= S_IDLE;
						line_valid[fill_index] <= 1'b1;
					end
			endcase
			if (fill_beat)
				fill_off <= fill_off + 1'b1; // Beats arrive in address order
		end
	end

	// Arrays and read data
	always_ff @(posedge clk)
	begin
		if (state == S_IDLE && ic_req && !hit)
		begin
			fill_tag <= cpu_tag;
			fill_index <= cpu_index;
		end
		if (fill_beat)
			data_mem[{fill_index, fill_off}] <= resp.data;
		if (fill_last)
			tag_mem[fill_index] <= fill_tag;
		if (ic_req)
			ic_data <= data_mem[{cpu_index, cpu_off}]; // Word shows one cycle later
	end

	// Icache beats only come back for our own outstanding line read
	a_beat_in_fill: assert property (@(posedge clk) disable iff (reset)
		(resp.valid && resp.did == FSAB_DID_ICACHE) |-> (state == S_FILL));
endmodule

//--- src/data_port.sv
`timescale 1ns/1ps

// Uncached load/store port, one single-beat bus request per access
module data_port import fsab_pkg::*, cpu_port_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic dc_rd_req,
	input logic dc_wr_req,
	input addr_t dc_addr,
	input word_t dc_wr_data,
	input mask_t dc_mask,
	output logic dc_wait,
	output word_t dc_rd_data,
	fsab_req_if.client req,
	input fsab_resp_t resp
);
	typedef enum logic [1:0]
	{
		S_IDLE,
		S_REQ, // Waiting for the arbiter
		S_WAIT // Load issued, waiting for its beat
	} state_t;

	state_t state;
	logic done_q; // Load completed last cycle, CPU still holds it
	logic wr_q; // Latched access kind
	addr_t addr_q;
	word_t data_q;
	mask_t mask_q;
	logic start;
	logic beat;

	assign start = (dc_rd_req || dc_wr_req) && !done_q;
	assign beat = (state == S_WAIT) && resp.valid && (resp.did == FSAB_DID_DPORT);

	always_comb
	begin
		case (state)
			S_IDLE: dc_wait = start;
			S_REQ: dc_wait = !(wr_q && req.accept); // Store ends at accept
			default: dc_wait = 1'b1;
		endcase
	end

	assign req.valid = (state == S_REQ);
	assign req.mode = wr_q ? FSAB_WRITE : FSAB_READ;
	assign req.did = FSAB_DID_DPORT;
	assign req.addr = addr_q;
	assign req.len = fsab_len_t'(1); // Always one beat
	assign req.data = data_q;
	assign req.mask = mask_q;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= S_IDLE;
			done_q <= 1'b0;
		end
		else
		begin
			done_q <= 1'b0;
			case (state)
				S_IDLE:
					if (start)
						state <= S_REQ;
				S_REQ:
					if (req.accept)
						state <= wr_q ? S_IDLE : S_WAIT;
				default:
					if (beat)
					begin
						state <= S_IDLE;
						done_q <= 1'b1; // Hides the held load for one cycle
					end
			endcase
		end
	end

	// Request fields and load data
	always_ff @(posedge clk)
	begin
		if (state == S_IDLE && start)
		begin
			wr_q <= dc_wr_req;
			addr_q <= {dc_addr[31:2], 2'b00}; // Word aligned
			data_q <= dc_wr_data;
			mask_q <= dc_mask;
		end
		if (beat)
			dc_rd_data <= resp.data;
	end

	// The CPU issues a load or a store, never both
	a_one_kind: assert property (@(posedge clk) disable iff (reset)
		!(dc_rd_req && dc_wr_req));
endmodule

//--- fsab/fsab_arbiter.sv
`timescale 1ns/1ps
`include "fsab_consts.svh"

// Two-client round-robin merge onto the bus, with credit tracking
module fsab_arbiter import fsab_pkg::*, cpu_port_pkg::*;
(
	input logic clk,
	input logic reset,
	fsab_req_if.arbiter ic_req,
	fsab_req_if.arbiter dp_req,
	output logic fsabo_valid,
	output fsab_mode_t fsabo_mode,
	output fsab_did_t fsabo_did,
	output addr_t fsabo_addr,
	output fsab_len_t fsabo_len,
	output word_t fsabo_data,
	output mask_t fsabo_mask,
	input logic fsabo_credit,
	input logic fsabi_valid,
	input fsab_did_t fsabi_did,
	input word_t fsabi_data,
	output fsab_resp_t resp
);
	localparam int CRED_W = $clog2(`FSAB_CREDITS + 1);

	logic [CRED_W-1:0] credits; // Requests the bus can still take
	logic have_credit;
	logic last_dp; // Data port got the last grant
	logic ic_wins;
	logic grant;

	assign have_credit = (credits != '0);

	// Icache wins when alone or when the data port went last
	assign ic_wins = ic_req.valid && (!dp_req.valid || last_dp);

	assign ic_req.accept = have_credit && ic_wins;
	assign dp_req.accept = have_credit && dp_req.valid && !ic_wins;
	assign grant = ic_req.accept || dp_req.accept;

	// Inbound beats go to both clients unregistered
	assign resp.valid = fsabi_valid;
	assign resp.did = fsabi_did;
	assign resp.data = fsabi_data;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			fsabo_valid <= 1'b0;
			credits <= CRED_W'(`FSAB_CREDITS);
			last_dp <= 1'b0;
		end
		else
		begin
			fsabo_valid <= grant; // On the bus one cycle after accept
			credits <= credits - CRED_W'(grant) + CRED_W'(fsabo_credit);
			if (grant)
				last_dp <= dp_req.accept;
		end
	end

	// Winner's fields
	always_ff @(posedge clk)
	begin
		if (ic_req.accept)
		begin
			fsabo_mode <= ic_req.mode;
			fsabo_did <= ic_req.did;
			fsabo_addr <= ic_req.addr;
			fsabo_len <= ic_req.len;
			fsabo_data <= ic_req.data;
			fsabo_mask <= ic_req.mask;
		end
		else if (dp_req.accept)
		begin
			fsabo_mode <= dp_req.mode;
			fsabo_did <= dp_req.did;
			fsabo_addr <= dp_req.addr;
			fsabo_len <= dp_req.len;
			fsabo_data <= dp_req.data;
			fsabo_mask <= dp_req.mask;
		end
	end

	// The bus never hands back more credits than it gave out
	a_credit_max: assert property (@(posedge clk) disable iff (reset)
		credits <= CRED_W'(`FSAB_CREDITS));
endmodule

//--- src/fire_mem_top.sv
`timescale 1ns/1ps

// Memory side: instruction cache and data port sharing one bus
module fire_mem_top import fsab_pkg::*, cpu_port_pkg::*;
(
	input logic clk,
	input logic reset,
	// Fetch port
	input logic ic_req,
	input addr_t ic_addr,
	output logic ic_wait,
	output word_t ic_data,
	// Load/store port
	input logic dc_rd_req,
	input logic dc_wr_req,
	input addr_t dc_addr,
	input word_t dc_wr_data,
	input mask_t dc_mask,
	output logic dc_wait,
	output word_t dc_rd_data,
	// System bus
	output logic fsabo_valid,
	output fsab_mode_t fsabo_mode,
	output fsab_did_t fsabo_did,
	output addr_t fsabo_addr,
	output fsab_len_t fsabo_len,
	output word_t fsabo_data,
	output mask_t fsabo_mask,
	input logic fsabo_credit,
	input logic fsabi_valid,
	input fsab_did_t fsabi_did,
	input word_t fsabi_data
);
	fsab_resp_t resp; // Shared response beat
	fsab_req_if ic_bus ();
	fsab_req_if dp_bus ();

	icache icache
	(
		.clk(clk), .reset(reset),
		.ic_req(ic_req), .ic_addr(ic_addr), .ic_wait(ic_wait), .ic_data(ic_data),
		.req(ic_bus.client), .resp(resp)
	);

	data_port data_port
	(
		.clk(clk), .reset(reset),
		.dc_rd_req(dc_rd_req), .dc_wr_req(dc_wr_req), .dc_addr(dc_addr),
		.dc_wr_data(dc_wr_data), .dc_mask(dc_mask),
		.dc_wait(dc_wait), .dc_rd_data(dc_rd_data),
		.req(dp_bus.client), .resp(resp)
	);

	fsab_arbiter fsab_arbiter
	(
		.clk(clk), .reset(reset),
		.ic_req(ic_bus.arbiter), .dp_req(dp_bus.arbiter),
		.fsabo_valid(fsabo_valid), .fsabo_mode(fsabo_mode), .fsabo_did(fsabo_did),
		.fsabo_addr(fsabo_addr), .fsabo_len(fsabo_len), .fsabo_data(fsabo_data),
		.fsabo_mask(fsabo_mask), .fsabo_credit(fsabo_credit),
		.fsabi_valid(fsabi_valid), .fsabi_did(fsabi_did), .fsabi_data(fsabi_data),
		.resp(resp)
	);
endmodule

//--- test/fsab_mem_model.sv
`timescale 1ns/1ps

// Bus memory: single-beat masked writes, burst reads, delayed credit return
module fsab_mem_model import fsab_pkg::*, cpu_port_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic hold_credits, // Owed credits stay back while high
	input logic fsabo_valid,
	input fsab_mode_t fsabo_mode,
	input fsab_did_t fsabo_did,
	input addr_t fsabo_addr,
	input fsab_len_t fsabo_len,
	input word_t fsabo_data,
	input mask_t fsabo_mask,
	output logic fsabo_credit,
	output logic fsabi_valid,
	output fsab_did_t fsabi_did,
	output word_t fsabi_data
);
	word_t mem [addr_t]; // Only words that were written
	addr_t beat_addr [$]; // Read beats still to send, in order
	fsab_did_t beat_did [$];
	logic [1:0] credit_delay; // Two cycles from request to credit
	int owed;

	// Unwritten words follow a pattern of the whole address
	function automatic word_t word_at(addr_t a);
		if (mem.exists(a))
			return mem[a];
		return a ^ 32'h5A5A_0000;
	endfunction

	always @(posedge clk)
	begin
		int owed_now;
		word_t merged;
		if (reset)
		begin
			fsabo_credit <= 1'b0;
			fsabi_valid <= 1'b0;
			fsabi_did <= FSAB_DID_DPORT;
			fsabi_data <= '0;
			credit_delay <= '0;
			owed = 0;
			beat_addr.delete();
			beat_did.delete();
		end
		else
		begin
			if (fsabo_valid && fsabo_mode == FSAB_WRITE)
			begin
				merged = word_at(fsabo_addr);
				for (int b = 0; b < 4; b++)
					if (fsabo_mask[b])
						merged[8*b +: 8] = fsabo_data[8*b +: 8]; // Masked byte lanes only
				mem[fsabo_addr] = merged;
			end
			else if (fsabo_valid)
			begin
				for (int i = 0; i < int'(fsabo_len); i++)
				begin
					beat_addr.push_back(fsabo_addr + addr_t'(4 * i));
					beat_did.push_back(fsabo_did);
				end
			end
			if (beat_addr.size() != 0)
			begin
				fsabi_valid <= 1'b1; // One beat per cycle, no gaps
				fsabi_did <= beat_did.pop_front();
				fsabi_data <= word_at(beat_addr.pop_front());
			end
			else
				fsabi_valid <= 1'b0;
			credit_delay <= {credit_delay[0], fsabo_valid};
			owed_now = owed + int'(credit_delay[1]);
			if (!hold_credits && owed_now > 0)
			begin
				fsabo_credit <= 1'b1;
				owed = owed_now - 1;
			end
			else
			begin
				fsabo_credit <= 1'b0;
				owed = owed_now; // Held back, paid later
			end
		end
	end
endmodule

//--- test/tb_fire_mem.sv
`timescale 1ns/1ps
`include "fsab_consts.svh"

module tb_fire_mem import fsab_pkg::*, cpu_port_pkg::*; ();
	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 10;
	localparam int FETCH_CYCLES = 40; // Longest line fill wait
	localparam int ACCESS_CYCLES = 20;
	localparam int HOLD_CYCLES = 40; // Credits withheld this long
	localparam int SETTLE_CYCLES = 10;
	localparam int STORE_COUNT = `FSAB_CREDITS + 2;
	localparam int TEST_CYCLES = RESET_CYCLES + 14 * FETCH_CYCLES + 10 * ACCESS_CYCLES
		+ HOLD_CYCLES + 6 * SETTLE_CYCLES;
	localparam word_t PATTERN = 32'h5A5A_0000;

	logic clk, reset, ic_req, ic_wait, dc_rd_req, dc_wr_req, dc_wait, hold_credits;
	addr_t ic_addr, dc_addr, fsabo_addr;
	word_t ic_data, dc_wr_data, dc_rd_data, fsabo_data, fsabi_data;
	mask_t dc_mask, fsabo_mask;
	logic fsabo_valid, fsabo_credit, fsabi_valid;
	fsab_mode_t fsabo_mode;
	fsab_did_t fsabo_did, fsabi_did;
	fsab_len_t fsabo_len;

	int seed, errors, checks, tests_run, tests_failed;
	word_t shadow [addr_t]; // Words the testbench has stored
	addr_t bus_addr [$]; // Every request seen on the bus
	fsab_did_t bus_did [$];
	fsab_mode_t bus_mode [$];
	fsab_len_t bus_len [$];
	addr_t fetch_a, evict_a, store_a, load_a, credit_a;

	fire_mem_top dut (.*);

	fsab_mem_model mem_model (.*);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Bus monitor samples the registered fsabo at the stable negedge
	always @(negedge clk)
	begin
		if (!reset && fsabo_valid)
		begin
			bus_addr.push_back(fsabo_addr);
			bus_did.push_back(fsabo_did);
			bus_mode.push_back(fsabo_mode);
			bus_len.push_back(fsabo_len);
		end
	end

	function automatic word_t expected_word(addr_t a);
		if (shadow.exists(a))
			return shadow[a];
		return a ^ PATTERN;
	endfunction

	function automatic addr_t line_base(addr_t a);
		return a & ~(addr_t'(`IC_LINE_WORDS * 4 - 1));
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		checks++;
		if (got !== expected)
		begin
			$display("FAIL t=%0t %s got=%h expected=%h", $time, name, got, expected);
			errors++;
		end
	endtask

	task automatic report_problem(input string what);
		$display("ERROR t=%0t %s", $time, what);
		errors++;
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	// Starts and ends 1 ns after a rising edge
	task automatic fetch_word(input addr_t a, output word_t data);
		int waited;
		waited = 0;
		ic_req = 1'b1;
		ic_addr = a;
		@(negedge clk);
		while (ic_wait && waited < FETCH_CYCLES)
		begin
			@(negedge clk);
			waited++;
		end
		if (ic_wait)
			report_problem($sformatf("fetch at %h did not finish in time", a));
		@(posedge clk);
		#1;
		ic_req = 1'b0;
		data = ic_data; // Loaded at the edge after ic_wait low
	endtask

	task automatic data_access(input logic write, input addr_t a, input word_t d,
		input mask_t m, input int limit, output word_t data);
		int waited;
		word_t merged;
		waited = 0;
		dc_rd_req = !write;
		dc_wr_req = write;
		dc_addr = a;
		dc_wr_data = d;
		dc_mask = m;
		@(negedge clk);
		while (dc_wait && waited < limit)
		begin
			@(negedge clk);
			waited++;
		end
		if (dc_wait)
			report_problem($sformatf("data access at %h did not finish in time", a));
		data = dc_rd_data;
		if (write)
		begin
			merged = expected_word(a);
			for (int b = 0; b < 4; b++)
				if (m[b])
					merged[8*b +: 8] = d[8*b +: 8];
			shadow[a] = merged;
		end
		@(posedge clk);
		#1;
		dc_rd_req = 1'b0;
		dc_wr_req = 1'b0;
	endtask

	// Exactly one line read for address a since entry n0
	task automatic check_line_read(input int n0, input addr_t a);
		check_value("line read count", bus_addr.size() - n0, 1);
		if (bus_addr.size() > n0)
		begin
			check_value("fsabo_did", bus_did[n0], FSAB_DID_ICACHE);
			check_value("fsabo_mode", bus_mode[n0], FSAB_READ);
			check_value("fsabo_len", bus_len[n0], `IC_LINE_WORDS);
			check_value("fsabo_addr", bus_addr[n0], line_base(a));
		end
	endtask

	task automatic finish_test(input string name, input int start_errors);
		tests_run++;
		if (errors == start_errors)
			$display("test %s: passed", name);
		else
		begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - start_errors);
		end
	endtask

	task automatic test_reset();
		int start_errors;
		start_errors = errors;
		@(negedge clk);
		check_value("fsabo_valid", fsabo_valid, 0);
		check_value("ic_wait", ic_wait, 0);
		check_value("dc_wait", dc_wait, 0);
		@(posedge clk);
		#1;
		finish_test("reset", start_errors);
	endtask

	task automatic test_icache_miss_hit();
		int start_errors, n0;
		word_t w;
		start_errors = errors;
		n0 = bus_addr.size();
		fetch_word(fetch_a, w);
		check_value("ic_data", w, expected_word(fetch_a));
		check_line_read(n0, fetch_a);
		n0 = bus_addr.size();
		for (int i = 0; i < `IC_LINE_WORDS; i++)
		begin
			fetch_word(line_base(fetch_a) + addr_t'(4 * i), w);
			check_value("ic_data", w, expected_word(line_base(fetch_a) + addr_t'(4 * i)));
		end
		check_value("requests on hits", bus_addr.size() - n0, 0);
		finish_test("icache miss and hit", start_errors);
	endtask

	task automatic test_store_load();
		int start_errors, n0;
		word_t w, d;
		start_errors = errors;
		d = $random(seed);
		n0 = bus_addr.size();
		data_access(1'b1, store_a, d, 4'b0101, ACCESS_CYCLES, w);
		wait_cycles(1); // Store reaches the bus one cycle after accept
		check_value("store request count", bus_addr.size() - n0, 1);
		if (bus_addr.size() > n0)
			check_value("fsabo_mode", bus_mode[n0], FSAB_WRITE);
		data_access(1'b0, store_a, '0, '0, ACCESS_CYCLES, w);
		check_value("dc_rd_data", w, expected_word(store_a));
		finish_test("store then load", start_errors);
	endtask

	task automatic test_concurrent();
		int start_errors, n0, ic_count, dp_count;
		word_t w_ic, w_dp;
		addr_t c;
		start_errors = errors;
		c = fetch_a + 32'h100; // Different index from the first line
		n0 = bus_addr.size();
		fork
			fetch_word(c, w_ic);
			data_access(1'b0, load_a, '0, '0, ACCESS_CYCLES, w_dp);
		join
		ic_count = 0;
		dp_count = 0;
		for (int i = n0; i < bus_addr.size(); i++)
			if (bus_did[i] == FSAB_DID_ICACHE)
				ic_count++;
			else
				dp_count++;
		check_value("ic_data", w_ic, expected_word(c));
		check_value("dc_rd_data", w_dp, expected_word(load_a));
		check_value("icache requests", ic_count, 1);
		check_value("data port requests", dp_count, 1);
		finish_test("concurrent miss and load", start_errors);
	endtask

	task automatic test_credit_backpressure();
		int start_errors, n0, held;
		start_errors = errors;
		wait_cycles(SETTLE_CYCLES); // All credits back home
		n0 = bus_addr.size();
		hold_credits = 1'b1;
		fork
			begin
				word_t unused;
				for (int i = 0; i < STORE_COUNT; i++)
					data_access(1'b1, credit_a + addr_t'(4 * i), PATTERN + word_t'(i), 4'hF,
						HOLD_CYCLES + ACCESS_CYCLES, unused);
			end
			begin
				wait_cycles(HOLD_CYCLES);
				held = bus_addr.size() - n0;
				if (held > `FSAB_CREDITS)
					report_problem("more requests on the bus than credits while held");
				check_value("requests while held", held, `FSAB_CREDITS);
				check_value("dc_wait", dc_wait, 1);
				hold_credits = 1'b0;
			end
		join
		wait_cycles(1); // Last store reaches the bus one cycle after accept
		check_value("requests after release", bus_addr.size() - n0, STORE_COUNT);
		finish_test("credit back-pressure", start_errors);
	endtask

	task automatic test_eviction();
		int start_errors, n0;
		word_t w;
		addr_t b;
		start_errors = errors;
		b = evict_a ^ 32'h400; // Same index, next tag
		fetch_word(evict_a, w);
		n0 = bus_addr.size();
		fetch_word(evict_a, w);
		check_value("requests on hit", bus_addr.size() - n0, 0);
		n0 = bus_addr.size();
		fetch_word(b, w);
		check_value("ic_data", w, expected_word(b));
		check_line_read(n0, b);
		n0 = bus_addr.size();
		fetch_word(evict_a, w);
		check_value("ic_data", w, expected_word(evict_a));
		check_line_read(n0, evict_a);
		finish_test("eviction", start_errors);
	endtask

	initial
	begin
		repeat (2 * TEST_CYCLES) @(posedge clk);
		$display("ERROR watchdog expired after %0d cycles", 2 * TEST_CYCLES);
		$display("STATUS: FAIL");
		$finish;
	end

	initial
	begin
		seed = 80;
		{errors, checks, tests_run, tests_failed} = '0;
		reset = 1'b1;
		{ic_req, dc_rd_req, dc_wr_req, hold_credits} = '0;
		ic_addr = '0;
		dc_addr = '0;
		dc_wr_data = '0;
		dc_mask = '0;
		fetch_a = $random(seed) & 32'h0000_FFFC; // Fetches below 64 KB
		evict_a = $random(seed) & 32'h0000_FFFC;
		store_a = 32'h0010_0000 | ($random(seed) & 32'h0000_FFFC); // Data well above
		load_a = 32'h0010_0000 | ($random(seed) & 32'h0000_FFFC);
		credit_a = 32'h0020_0000 | ($random(seed) & 32'h0000_FFC0);
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset = 1'b0;
		test_reset();
		test_icache_miss_hit();
		test_store_load();
		test_concurrent();
		test_credit_backpressure();
		test_eviction();
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end
endmodule

//--- fire_mem.f
+incdir+common
common/fsab_pkg.sv
common/cpu_port_pkg.sv
common/fsab_req_if.sv
icache/icache.sv
src/data_port.sv
fsab/fsab_arbiter.sv
src/fire_mem_top.sv
test/fsab_mem_model.sv
test/tb_fire_mem.sv

//--- Makefile
VERILATOR = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP = tb_fire_mem
FILELIST = fire_mem.f
OBJ_DIR = obj_dir
BIN = $(OBJ_DIR)/V$(TOP)
LOG = sim.log
PASS_MSG = STATUS: PASS
SRCS = $(shell grep -v '^+' $(FILELIST)) common/fsab_consts.svh

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
